//--- hdl/config_pkg.sv
// package with the data memory size, byte address width and data width
package config_pkg;

  // the effective address wraps modulo this memory size in bytes
  localparam int unsigned mem_size = 4096;

  // byte address width into the data memory
  localparam int unsigned mem_addr_width = $clog2(mem_size);

  // width of register values, base and load/store data
  localparam int unsigned xlen = 32;

endpackage

//--- hdl/mem_pkg.sv
// package with width and fault enums, load/store opcodes, funct3 codes and the instruction union
package mem_pkg;

  // size of a single memory access
  typedef enum logic [1:0] {
    byte_access     = 2'd0,
    halfword_access = 2'd1,
    word_access     = 2'd2
  } mem_width_t;

  // reason for the fault that is held in the response stage
  typedef enum logic [1:0] {
    fault_none             = 2'd0,
    fault_load_misaligned  = 2'd1,
    fault_store_misaligned = 2'd2,
    fault_illegal          = 2'd3
  } fault_cause_t;

  localparam logic [6:0] opcode_load  = 7'b0000011;
  localparam logic [6:0] opcode_store = 7'b0100011;

  // the signed funct3 codes are shared by loads and stores
  localparam logic [2:0] funct3_b  = 3'b000;
  localparam logic [2:0] funct3_h  = 3'b001;
  localparam logic [2:0] funct3_w  = 3'b010;
  localparam logic [2:0] funct3_bu = 3'b100;
  localparam logic [2:0] funct3_hu = 3'b101;

  // one instruction word that is read as I-type for loads and as S-type for stores
  typedef union packed {
    struct packed {
      logic [11:0] imm;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i_form;
    struct packed {
      logic [6:0]  imm_hi;
      logic [4:0]  rs2;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  imm_lo;
      logic [6:0]  opcode;
    } s_form;
  } ls_instr_t;

endpackage

//--- hdl/lsu_request.sv
// module for load/store decode, immediate select and effective address generation
`timescale 1ns/100ps

module lsu_request (
  input  logic                        instr_valid,
  input  mem_pkg::ls_instr_t          instr,
  input  logic [config_pkg::xlen-1:0] base,
  output logic                        write_enable,
  output mem_pkg::mem_width_t         width,
  output logic                        sign_extend,
  output logic [config_pkg::xlen-1:0] eff_addr,
  output logic                        is_load,
  output logic                        is_store,
  output logic                        illegal
);

  logic        load_op;
  logic        store_op;
  logic        load_f3_ok;
  logic        store_f3_ok;
  logic [11:0] imm;

  // opcode and funct3 sit at the same bits in both layouts
  assign load_op  = (instr.i_form.opcode == mem_pkg::opcode_load);
  assign store_op = (instr.s_form.opcode == mem_pkg::opcode_store);

  always_comb begin
    width       = mem_pkg::byte_access;
    sign_extend = 1'b0;
    load_f3_ok  = 1'b1;
    case (instr.i_form.funct3)
      mem_pkg::funct3_b: begin
        width       = mem_pkg::byte_access;
        sign_extend = 1'b1;
      end
      mem_pkg::funct3_h: begin
        width       = mem_pkg::halfword_access;
        sign_extend = 1'b1;
      end
      mem_pkg::funct3_w: begin
        width       = mem_pkg::word_access;
        sign_extend = 1'b1;
      end
      mem_pkg::funct3_bu: width = mem_pkg::byte_access;
      mem_pkg::funct3_hu: width = mem_pkg::halfword_access;
      default: load_f3_ok = 1'b0;
    endcase
  end

  // bit 2 set is an unsigned load code that stores do not have
  assign store_f3_ok = load_f3_ok && !instr.s_form.funct3[2];

  // S-type splits the immediate around rs2 and rs1
  assign imm = load_op ? instr.i_form.imm : {instr.s_form.imm_hi, instr.s_form.imm_lo};

  assign eff_addr = base + {{(config_pkg::xlen - 12){imm[11]}}, imm};

  assign is_load  = instr_valid && load_op && load_f3_ok;
  assign is_store = instr_valid && store_op && store_f3_ok;

  // anything valid that is neither a legal load nor a legal store
  assign illegal = instr_valid && !is_load && !is_store;

  assign write_enable = is_store; // illegal words never reach the memory

endmodule

//--- hdl/data_mem.sv
// byte-lane data memory module with combinational extending read and alignment check
`timescale 1ns/100ps

module data_mem (
  input  logic                                  clk,
  input  logic                                  write_enable,
  input  mem_pkg::mem_width_t                   width,
  input  logic                                  sign_extend,
  input  logic [config_pkg::mem_addr_width-1:0] address,
  input  logic [config_pkg::xlen-1:0]           data_in,
  output logic [config_pkg::xlen-1:0]           data_out,
  output logic                                  alignment_error
);

  localparam int unsigned word_count = config_pkg::mem_size / 4;

  logic [3:0][7:0] mem [word_count];
  logic [config_pkg::mem_addr_width-3:0] word_index;
  logic [3:0][7:0] read_word;
  logic [3:0][7:0] write_word;
  logic [7:0]      byte_lane;
  logic [15:0]     half_lane;

  assign word_index = address[config_pkg::mem_addr_width-1:2];
  assign read_word  = mem[word_index];

  // the halfword read ignores address bit 0
  assign byte_lane = read_word[address[1:0]];
  assign half_lane = {read_word[{address[1], 1'b1}], read_word[{address[1], 1'b0}]};

  // merge the store data into the current word
  always_comb begin
    write_word = read_word;
    case (width)
      mem_pkg::byte_access: write_word[address[1:0]] = data_in[7:0];
      mem_pkg::halfword_access: begin
        // an odd address still writes the aligned halfword around it
        write_word[{address[1], 1'b1}] = data_in[15:8];
        write_word[{address[1], 1'b0}] = data_in[7:0];
      end
      mem_pkg::word_access: write_word = data_in; // whole word even if misaligned
      default: write_word = read_word;
    endcase
  end

  always_ff @(posedge clk) begin
    if (write_enable) begin
      mem[word_index] <= write_word;
    end
  end

  always_comb begin
    case (width)
      mem_pkg::byte_access: begin
        alignment_error = 1'b0;
        data_out = {{24{sign_extend && byte_lane[7]}}, byte_lane};
      end
      mem_pkg::halfword_access: begin
        alignment_error = address[0];
        data_out = {{16{sign_extend && half_lane[15]}}, half_lane};
      end
      mem_pkg::word_access: begin
        alignment_error = (address[1:0] != 2'b00);
        data_out = read_word;
      end
      default: begin
        alignment_error = 1'b0;
        data_out = '0;
      end
    endcase
  end

endmodule

//--- hdl/lsu_response.sv
// module with the load result register, its valid pulse and first-fault capture
`timescale 1ns/100ps

module lsu_response (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        is_load,
  input  logic                        is_store,
  input  logic                        illegal,
  input  logic                        alignment_error,
  input  logic [config_pkg::xlen-1:0] data_out,
  input  logic [config_pkg::xlen-1:0] eff_addr,
  input  logic                        fault_clear,
  output logic                        load_valid,
  output logic [config_pkg::xlen-1:0] load_data,
  output logic                        fault_valid,
  output mem_pkg::fault_cause_t       fault_cause,
  output logic [config_pkg::xlen-1:0] fault_addr
);

  mem_pkg::fault_cause_t new_cause;
  logic                  capture_fault;

  // alignment_error only means something for a legal access
  always_comb begin
    if (illegal) begin
      new_cause = mem_pkg::fault_illegal;
    end else if (is_load && alignment_error) begin
      new_cause = mem_pkg::fault_load_misaligned;
    end else if (is_store && alignment_error) begin
      new_cause = mem_pkg::fault_store_misaligned;
    end else begin
      new_cause = mem_pkg::fault_none;
    end
  end

  // a clear in the same cycle frees the slot for the new fault
  assign capture_fault = (new_cause != mem_pkg::fault_none) && (!fault_valid || fault_clear);

  always_ff @(posedge clk) begin
    if (reset) begin
      load_valid  <= 1'b0;
      fault_valid <= 1'b0;
      fault_cause <= mem_pkg::fault_none;
    end else begin
      load_valid <= is_load; // misaligned loads still return data
      if (capture_fault) begin
        fault_valid <= 1'b1;
        fault_cause <= new_cause;
      end else if (fault_clear) begin
        fault_valid <= 1'b0;
        fault_cause <= mem_pkg::fault_none;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (is_load) begin
      load_data <= data_out; // held until the next load
    end
    if (capture_fault) begin
      fault_addr <= eff_addr;
    end
  end

endmodule

//--- hdl/lsu_top.sv
// top level of the load/store path with request decode, data memory and response stage
`timescale 1ns/100ps

module lsu_top (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        instr_valid,
  input  mem_pkg::ls_instr_t          instr,
  input  logic [config_pkg::xlen-1:0] base,
  input  logic [config_pkg::xlen-1:0] store_data,
  input  logic                        fault_clear,
  output logic                        load_valid,
  output logic [config_pkg::xlen-1:0] load_data,
  output logic                        fault_valid,
  output mem_pkg::fault_cause_t       fault_cause,
  output logic [config_pkg::xlen-1:0] fault_addr
);

  logic                        write_enable;
  mem_pkg::mem_width_t         width;
  logic                        sign_extend;
  logic [config_pkg::xlen-1:0] eff_addr;
  logic                        is_load;
  logic                        is_store;
  logic                        illegal;
  logic [config_pkg::xlen-1:0] data_out;
  logic                        alignment_error;

  lsu_request lsu_request_i (
    .instr_valid (instr_valid),
    .instr       (instr),
    .base        (base),
    .write_enable(write_enable),
    .width       (width),
    .sign_extend (sign_extend),
    .eff_addr    (eff_addr),
    .is_load     (is_load),
    .is_store    (is_store),
    .illegal     (illegal)
  );

  // upper address bits are dropped so accesses wrap around the memory
  data_mem data_mem_i (
    .clk            (clk),
    .write_enable   (write_enable),
    .width          (width),
    .sign_extend    (sign_extend),
    .address        (eff_addr[config_pkg::mem_addr_width-1:0]),
    .data_in        (store_data),
    .data_out       (data_out),
    .alignment_error(alignment_error)
  );

  lsu_response lsu_response_i (
    .clk            (clk),
    .reset          (reset),
    .is_load        (is_load),
    .is_store       (is_store),
    .illegal        (illegal),
    .alignment_error(alignment_error),
    .data_out       (data_out),
    .eff_addr       (eff_addr),
    .fault_clear    (fault_clear),
    .load_valid     (load_valid),
    .load_data      (load_data),
    .fault_valid    (fault_valid),
    .fault_cause    (fault_cause),
    .fault_addr     (fault_addr)
  );

endmodule

//--- dv/lsu_props.sv
// checker module with concurrent assertions on the load/store outputs and its bind to lsu_top
`timescale 1ns/100ps

module lsu_props (
  input logic                  clk,
  input logic                  reset,
  input logic                  instr_valid,
  input logic                  load_valid,
  input logic                  fault_valid,
  input mem_pkg::fault_cause_t fault_cause
);

  int unsigned failure_count = 0; // read by the testbench when the run ends

  // one instruction gives at most one load_valid cycle
  single_load_pulse: assert property (@(posedge clk) disable iff (reset)
    ($past(instr_valid) && !instr_valid) |=> !load_valid)
    else begin
      failure_count++;
      $error("load_valid stayed high after a single instruction");
    end

  load_follows_instr: assert property (@(posedge clk) disable iff (reset)
    load_valid |-> $past(instr_valid))
    else begin
      failure_count++;
      $error("load_valid without an instruction in the cycle before");
    end

  // a held fault always has a real cause
  cause_matches_valid: assert property (@(posedge clk) disable iff (reset)
    fault_valid == (fault_cause != mem_pkg::fault_none))
    else begin
      failure_count++;
      $error("fault_cause does not agree with fault_valid");
    end

  outputs_idle_after_reset: assert property (@(posedge clk)
    reset |=> (!load_valid && !fault_valid && fault_cause == mem_pkg::fault_none))
    else begin
      failure_count++;
      $error("outputs active in the cycle after reset");
    end

endmodule

bind lsu_top lsu_props lsu_props_i (
  .clk        (clk),
  .reset      (reset),
  .instr_valid(instr_valid),
  .load_valid (load_valid),
  .fault_valid(fault_valid),
  .fault_cause(fault_cause)
);

//--- dv/lsu_tb.sv
// testbench with clock, reset, directed and random stimulus, reference model and output checks
`timescale 1ns/100ps

module lsu_tb;

  localparam int reset_cycles    = 8;
  localparam int fill_count      = config_pkg::mem_size / 4;
  localparam int directed_count  = 44; // directed instructions and idle cycles after the fill
  localparam int random_count    = 300;
  localparam int cycle_limit     = reset_cycles + fill_count + directed_count + random_count + 50;

  logic                  clk;
  logic                  reset;
  logic                  instr_valid;
  mem_pkg::ls_instr_t    instr;
  logic [31:0]           base;
  logic [31:0]           store_data;
  logic                  fault_clear;
  logic                  load_valid;
  logic [31:0]           load_data;
  logic                  fault_valid;
  mem_pkg::fault_cause_t fault_cause;
  logic [31:0]           fault_addr;

  logic [7:0]            shadow [config_pkg::mem_size]; // byte image of the data memory
  logic                  exp_load_valid;
  logic [31:0]           exp_load_data;
  logic                  exp_fault_valid;
  mem_pkg::fault_cause_t exp_fault_cause;
  logic [31:0]           exp_fault_addr;
  int                    check_count = 0;
  int                    error_count = 0;
  int                    seed = 32'h9783;

  lsu_top lsu_top_i (
    .clk        (clk),
    .reset      (reset),
    .instr_valid(instr_valid),
    .instr      (instr),
    .base       (base),
    .store_data (store_data),
    .fault_clear(fault_clear),
    .load_valid (load_valid),
    .load_data  (load_data),
    .fault_valid(fault_valid),
    .fault_cause(fault_cause),
    .fault_addr (fault_addr)
  );

  initial begin : clock_gen
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic mem_pkg::ls_instr_t encode_load(input logic [2:0] f3, input logic [11:0] imm);
    mem_pkg::ls_instr_t w;
    w = '0;
    w.i_form.opcode = mem_pkg::opcode_load;
    w.i_form.funct3 = f3;
    w.i_form.imm    = imm;
    w.i_form.rs1    = 5'd2;
    w.i_form.rd     = 5'd5;
    return w;
  endfunction

  function automatic mem_pkg::ls_instr_t encode_store(input logic [2:0] f3, input logic [11:0] imm);
    mem_pkg::ls_instr_t w;
    w = '0;
    w.s_form.opcode = mem_pkg::opcode_store;
    w.s_form.funct3 = f3;
    w.s_form.imm_hi = imm[11:5]; // S-type keeps the upper bits above rs2
    w.s_form.imm_lo = imm[4:0];
    w.s_form.rs1    = 5'd2;
    w.s_form.rs2    = 5'd6;
    return w;
  endfunction

  function automatic mem_pkg::ls_instr_t encode_other(input logic [6:0] opcode,
                                                      input logic [2:0] f3);
    mem_pkg::ls_instr_t w;
    w = '0;
    w.i_form.opcode = opcode;
    w.i_form.funct3 = f3;
    w.i_form.imm    = 12'h010;
    return w;
  endfunction

  function automatic logic [2:0] pick_load_f3(input logic [2:0] pick);
    case (pick)
      3'd0, 3'd5: return 3'b000;
      3'd1, 3'd6: return 3'b001;
      3'd3:       return 3'b100;
      3'd4:       return 3'b101;
      default:    return 3'b010;
    endcase
  endfunction

  function automatic logic [2:0] pick_store_f3(input logic [1:0] pick);
    return (pick == 2'b11) ? 3'b010 : {1'b0, pick};
  endfunction

  // fill pattern built from every address bit
  function automatic logic [31:0] fill_word(input logic [11:0] a);
    return {a, 4'h5, ~a, 4'ha};
  endfunction

  // expected decode, address, load value and fault cause from the RV32 encoding rules
  function automatic void model_access(
    input  logic                  valid,
    input  logic [31:0]           word,
    input  logic [31:0]           base_value,
    output logic                  load_ok,
    output logic                  store_ok,
    output logic [31:0]           addr,
    output logic [31:0]           value,
    output mem_pkg::fault_cause_t cause
  );
    logic [6:0]  opcode;
    logic [2:0]  f3;
    logic [11:0] imm;
    logic [11:0] a;
    logic [7:0]  b;
    logic [15:0] h;
    logic        misaligned;
    opcode   = word[6:0];
    f3       = word[14:12];
    load_ok  = valid && opcode == 7'b0000011 &&
               (f3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101});
    store_ok = valid && opcode == 7'b0100011 && (f3 inside {3'b000, 3'b001, 3'b010});
    imm  = (opcode == 7'b0000011) ? word[31:20] : {word[31:25], word[11:7]};
    addr = base_value + {{20{imm[11]}}, imm};
    a    = addr[11:0]; // memory wraps at 4 KiB
    b    = shadow[a];
    h    = {shadow[{a[11:1], 1'b1}], shadow[{a[11:1], 1'b0}]};
    misaligned = 1'b0;
    value      = '0;
    case (f3[1:0])
      2'b00: value = {{24{!f3[2] && b[7]}}, b};
      2'b01: begin
        misaligned = a[0];
        value      = {{16{!f3[2] && h[15]}}, h};
      end
      2'b10: begin
        misaligned = (a[1:0] != 2'b00);
        value = {shadow[{a[11:2], 2'b11}], shadow[{a[11:2], 2'b10}],
                 shadow[{a[11:2], 2'b01}], shadow[{a[11:2], 2'b00}]};
      end
      default: value = '0;
    endcase
    if (valid && !load_ok && !store_ok) begin
      cause = mem_pkg::fault_illegal;
    end else if (load_ok && misaligned) begin
      cause = mem_pkg::fault_load_misaligned;
    end else if (store_ok && misaligned) begin
      cause = mem_pkg::fault_store_misaligned;
    end else begin
      cause = mem_pkg::fault_none;
    end
  endfunction

  // misaligned stores land in the aligned halfword or word
  task automatic write_shadow(input logic [11:0] a, input logic [2:0] f3, input logic [31:0] data);
    case (f3[1:0])
      2'b00: shadow[a] = data[7:0];
      2'b01: begin
        shadow[{a[11:1], 1'b0}] = data[7:0];
        shadow[{a[11:1], 1'b1}] = data[15:8];
      end
      default: begin
        shadow[{a[11:2], 2'b00}] = data[7:0];
        shadow[{a[11:2], 2'b01}] = data[15:8];
        shadow[{a[11:2], 2'b10}] = data[23:16];
        shadow[{a[11:2], 2'b11}] = data[31:24];
      end
    endcase
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("[ERROR] %0t %s: got %h, expected %h", $time, name, actual, expected);
    end
  endtask

  task automatic issue(input mem_pkg::ls_instr_t word, input logic [31:0] base_value,
                       input logic [31:0] data, input logic clear);
    @(negedge clk);
    instr_valid = 1'b1;
    instr       = word;
    base        = base_value;
    store_data  = data;
    fault_clear = clear;
  endtask

  task automatic idle(input logic clear);
    @(negedge clk);
    instr_valid = 1'b0;
    fault_clear = clear;
  endtask

  // the model takes the inputs at the rising edge and the outputs are checked 1 ns later
  always @(posedge clk) begin : compare_outputs
    logic                  ld;
    logic                  st;
    logic [31:0]           word;
    logic [31:0]           addr;
    logic [31:0]           value;
    mem_pkg::fault_cause_t cause;
    word = instr;
    if (reset) begin
      exp_load_valid  = 1'b0;
      exp_fault_valid = 1'b0;
      exp_fault_cause = mem_pkg::fault_none;
    end else begin
      model_access(instr_valid, word, base, ld, st, addr, value, cause);
      exp_load_valid = ld;
      if (ld) exp_load_data = value;
      if (st) write_shadow(addr[11:0], word[14:12], store_data);
      if (cause != mem_pkg::fault_none && (!exp_fault_valid || fault_clear)) begin
        exp_fault_valid = 1'b1;
        exp_fault_cause = cause;
        exp_fault_addr  = addr;
      end else if (fault_clear) begin
        exp_fault_valid = 1'b0;
        exp_fault_cause = mem_pkg::fault_none;
      end
    end
    #1;
    check_value("load_valid", {31'b0, load_valid}, {31'b0, exp_load_valid});
    if (exp_load_valid) check_value("load_data", load_data, exp_load_data);
    check_value("fault_valid", {31'b0, fault_valid}, {31'b0, exp_fault_valid});
    check_value("fault_cause", {30'b0, fault_cause}, {30'b0, exp_fault_cause});
    if (exp_fault_valid) check_value("fault_addr", fault_addr, exp_fault_addr);
  end

  initial begin : watchdog
    int cycle_count;
    cycle_count = 0;
    while (cycle_count < cycle_limit) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout: the stimulus did not finish within %0d cycles", cycle_limit);
    $display("Simulation failed");
    $finish;
  end

  initial begin : stimulus
    logic [11:0]        a;
    logic [31:0]        sel;
    logic [31:0]        data;
    logic [31:0]        base_value;
    logic [11:0]        imm;
    mem_pkg::ls_instr_t word;
    int                 assert_failures;
    reset       = 1'b1;
    instr_valid = 1'b0;
    instr       = '0;
    base        = '0;
    store_data  = '0;
    fault_clear = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    a = '0;
    for (int i = 0; i < fill_count; i++) begin
      issue(encode_store(3'b010, 12'h010), {20'h7a5c3, a} - 32'd16, fill_word(a), 1'b0);
      a = a + 12'd4;
    end

    issue(encode_store(3'b010, 12'h7fc), 32'h0000_0100, 32'hdead_beef, 1'b0);
    issue(encode_load(3'b010, 12'h804), 32'h0000_10f8, 32'h0, 1'b0); // negative offset
    issue(encode_store(3'b010, 12'hffc), 32'h0000_0000, 32'h1234_5678, 1'b0); // wraps to 0xffc
    issue(encode_load(3'b010, 12'h004), 32'h0000_0ff8, 32'h0, 1'b0);
    issue(encode_store(3'b010, 12'h020), 32'h8000_0200, 32'hcafe_f00d, 1'b0);
    issue(encode_load(3'b010, 12'h000), 32'h0000_0220, 32'h0, 1'b0);

    issue(encode_store(3'b000, 12'h001), 32'h300, 32'h0000_00f1, 1'b0);
    issue(encode_store(3'b001, 12'h006), 32'h300, 32'h5555_8a7b, 1'b0);
    issue(encode_load(3'b000, 12'h001), 32'h300, 32'h0, 1'b0);
    issue(encode_load(3'b100, 12'h001), 32'h300, 32'h0, 1'b0);
    issue(encode_load(3'b001, 12'h006), 32'h300, 32'h0, 1'b0);
    issue(encode_load(3'b101, 12'h006), 32'h300, 32'h0, 1'b0);
    issue(encode_load(3'b010, 12'h000), 32'h300, 32'h0, 1'b0);
    issue(encode_load(3'b010, 12'h004), 32'h300, 32'h0, 1'b0);
    issue(encode_load(3'b000, 12'h002), 32'h300, 32'h0, 1'b0); // neighbour lane untouched
    issue(encode_store(3'b000, 12'h003), 32'h300, 32'hffff_ff7f, 1'b0);
    issue(encode_load(3'b000, 12'h003), 32'h300, 32'h0, 1'b0);

    issue(encode_load(3'b001, 12'h005), 32'h300, 32'h0, 1'b0);
    idle(1'b1);
    issue(encode_load(3'b010, 12'h002), 32'h300, 32'h0, 1'b0);
    idle(1'b1);
    issue(encode_store(3'b001, 12'h011), 32'h300, 32'h0000_a1b2, 1'b0);
    idle(1'b1);
    issue(encode_store(3'b010, 12'h017), 32'h300, 32'h0bad_f00d, 1'b0);
    idle(1'b1);
    issue(encode_load(3'b010, 12'h010), 32'h300, 32'h0, 1'b0);
    issue(encode_load(3'b010, 12'h014), 32'h300, 32'h0, 1'b0);

    issue(encode_store(3'b100, 12'h020), 32'h300, 32'hffff_ffff, 1'b0); // must not write 0x320
    idle(1'b1);
    issue(encode_load(3'b011, 12'h020), 32'h300, 32'h0, 1'b0);
    idle(1'b1);
    issue(encode_other(7'b0110011, 3'b000), 32'h300, 32'h0, 1'b0);
    idle(1'b1);
    issue(encode_load(3'b010, 12'h020), 32'h300, 32'h0, 1'b0);

    issue(encode_load(3'b001, 12'h031), 32'h300, 32'h0, 1'b0);
    issue(encode_store(3'b010, 12'h032), 32'h300, 32'h1111_2222, 1'b0);
    issue(encode_other(7'b1111111, 3'b111), 32'h300, 32'h0, 1'b0);
    issue(encode_load(3'b010, 12'h030), 32'h300, 32'h0, 1'b0);
    issue(encode_other(7'b0010011, 3'b000), 32'h300, 32'h0, 1'b1); // clear with a new fault
    idle(1'b1);
    issue(encode_store(3'b010, 12'h043), 32'h300, 32'h3333_4444, 1'b0);
    idle(1'b1);

    for (int n = 0; n < random_count; n++) begin
      sel        = $random(seed);
      data       = $random(seed);
      base_value = $random(seed);
      imm        = sel[31:20];
      if (sel[7]) base_value[1:0] = 2'b00 - imm[1:0]; // force an aligned address
      case (sel[9:8])
        2'b00, 2'b01: word = encode_load(pick_load_f3(sel[6:4]), imm);
        2'b10:        word = encode_store(pick_store_f3(sel[5:4]), imm);
        default: begin
          if (sel[10]) word = encode_other(sel[16:10], sel[6:4]);
          else word = encode_store(pick_store_f3(sel[5:4]), imm);
        end
      endcase
      issue(word, base_value, data, sel[19:17] == 3'b000);
    end
    idle(1'b0);
    idle(1'b0);

    assert_failures = lsu_top_i.lsu_props_i.failure_count;
    $display("checks: %0d, value errors: %0d, assertion failures: %0d",
             check_count, error_count, assert_failures);
    if (error_count == 0 && assert_failures == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- src.f
hdl/config_pkg.sv
hdl/mem_pkg.sv
hdl/lsu_request.sv
hdl/data_mem.sv
hdl/lsu_response.sv
hdl/lsu_top.sv
dv/lsu_props.sv
dv/lsu_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the load/store path testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing --top-module lsu_tb -f src.f -o lsu_sim
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "verilator build failed with status $build_status"
  exit 1
fi

sim_output=$(./obj_dir/lsu_sim +verilator+error+limit+1000)
sim_status=$?
printf '%s\n' "$sim_output"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if printf '%s\n' "$sim_output" | grep -qx "Simulation completed successfully"; then
  exit 0
fi

echo "pass message not found in simulation output"
exit 1
